// File: verilog/sqr_num_pkg.sv
// Number format for the modular squarer
// Word widths, table geometry, the 64-bit modulus and the typedefs
// reduce_entry builds one reduction table row from a column index and an address

`default_nettype none

package sqr_num_pkg;

   localparam int WORD_LEN        = 16;   // Weight step between words
   localparam int BIT_LEN         = 17;   // Stored word, one overlap bit
   localparam int NUM_ELEMENTS    = 6;
   localparam int NONRED_ELEMENTS = 4;
   localparam int GRID_SIZE       = 2 * NUM_ELEMENTS;
   localparam int LOOK_UP_WIDTH   = 8;    // Low byte split point
   localparam int LUT_ADDR_LEN    = 9;
   localparam int LUT_ENTRIES     = 512;
   localparam int ACC_BIT_LEN     = 29;
   localparam int COL_BIT_LEN     = 38;

   // 2^64 - 59
   localparam logic [NONRED_ELEMENTS*WORD_LEN-1:0] MODULUS = 64'hFFFF_FFFF_FFFF_FFC5;

   typedef logic [BIT_LEN-1:0]                  word_t;
   typedef logic [LUT_ADDR_LEN-1:0]             lut_addr_t;
   typedef logic [NONRED_ELEMENTS*WORD_LEN-1:0] lut_entry_t;
   typedef logic [ACC_BIT_LEN-1:0]              acc_t;

   // (addr * 2^(16*col)) mod MODULUS by doubling, one spare bit for the compare
   function automatic lut_entry_t reduce_entry(input int col, input lut_addr_t addr);
      logic [NONRED_ELEMENTS*WORD_LEN:0] w;
      logic [NONRED_ELEMENTS*WORD_LEN:0] r;
      w = 1;
      for (int s = 0; s < col * WORD_LEN; s++) begin
         w = w << 1;
         if (w >= MODULUS) w = w - MODULUS;
      end
      r = '0;
      for (int b = LUT_ADDR_LEN - 1; b >= 0; b--) begin
         r = r << 1;
         if (r >= MODULUS) r = r - MODULUS;
         if (addr[b]) begin
            r = r + w;
            if (r >= MODULUS) r = r - MODULUS;
         end
      end
      return lut_entry_t'(r);
   endfunction

endpackage

`default_nettype wire

// File: verilog/sqr_ctrl_pkg.sv
// Control definitions for the modular squarer
// Cycle state encoding and iteration length

`default_nettype none

package sqr_ctrl_pkg;

   // One-hot cycle states
   typedef enum logic [4:0] {
      IDLE       = 5'b00001,
      SQUARE     = 5'b00010,
      LOOK_LOW   = 5'b00100,
      LOOK_HIGH  = 5'b01000,
      ACCUMULATE = 5'b10000
   } cycle_t;

   localparam int ITER_CYCLES = 4;   // SQUARE through ACCUMULATE

endpackage

`default_nettype wire

// File: verilog/square_sequencer.sv
// Cycle sequencer for the modular squarer
// Start capture, four-cycle iteration loop, strobe decode and valid pulse

`timescale 1ns/1ns
`default_nettype none

module square_sequencer (
   input  logic clk,
   input  logic reset,
   input  logic start,
   output logic load_operand,
   output logic use_input,
   output logic shift_high,
   output logic hold_low,
   output logic write_result,
   output logic valid
);

   sqr_ctrl_pkg::cycle_t state;
   sqr_ctrl_pkg::cycle_t state_next;
   logic                 first_iter;   // Squaring the loaded operand, not sq_out

   always_comb begin
      state_next = state;
      case (state)
         sqr_ctrl_pkg::IDLE:       if (start) state_next = sqr_ctrl_pkg::SQUARE;
         sqr_ctrl_pkg::SQUARE:     state_next = sqr_ctrl_pkg::LOOK_LOW;
         sqr_ctrl_pkg::LOOK_LOW:   state_next = sqr_ctrl_pkg::LOOK_HIGH;
         sqr_ctrl_pkg::LOOK_HIGH:  state_next = sqr_ctrl_pkg::ACCUMULATE;
         sqr_ctrl_pkg::ACCUMULATE: state_next = sqr_ctrl_pkg::SQUARE;
         default:                  state_next = sqr_ctrl_pkg::IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state      <= sqr_ctrl_pkg::IDLE;
         valid      <= 1'b0;
         first_iter <= 1'b0;
      end else begin
         state <= state_next;
         valid <= write_result;          // Result lands in sq_out at this edge
         if (load_operand) begin
            first_iter <= 1'b1;
         end else if (write_result) begin
            first_iter <= 1'b0;
         end
      end
   end

   assign load_operand = (state == sqr_ctrl_pkg::IDLE) && start;
   assign use_input    = first_iter;   // Held so the grid keeps the loaded operand
   assign shift_high   = (state == sqr_ctrl_pkg::LOOK_HIGH);
   assign hold_low     = (state == sqr_ctrl_pkg::LOOK_HIGH);
   assign write_result = (state == sqr_ctrl_pkg::ACCUMULATE);

   a_state_legal: assert property (@(posedge clk) disable iff (reset)
      state inside {sqr_ctrl_pkg::IDLE, sqr_ctrl_pkg::SQUARE, sqr_ctrl_pkg::LOOK_LOW,
                    sqr_ctrl_pkg::LOOK_HIGH, sqr_ctrl_pkg::ACCUMULATE});

   // Pulses are spaced one iteration apart
   a_valid_spacing: assert property (@(posedge clk) disable iff (reset)
      valid |=> !valid [*(sqr_ctrl_pkg::ITER_CYCLES - 1)]);

endmodule

`default_nettype wire

// File: verilog/square_grid.sv
// Squaring grid of the modular squarer
// Operand capture and select, upper-triangle column products,
// partial carry reduction to 17-bit words and the grid register

`timescale 1ns/1ns
`default_nettype none

module square_grid (
   input  logic               clk,
   input  logic               load_operand,
   input  logic               use_input,
   input  sqr_num_pkg::word_t sq_in      [sqr_num_pkg::NUM_ELEMENTS],
   input  sqr_num_pkg::word_t sq_out     [sqr_num_pkg::NUM_ELEMENTS],
   output sqr_num_pkg::word_t grid_words [sqr_num_pkg::GRID_SIZE]
);

   sqr_num_pkg::word_t                   in_reg  [sqr_num_pkg::NUM_ELEMENTS];
   sqr_num_pkg::word_t                   opnd    [sqr_num_pkg::NUM_ELEMENTS];
   logic [sqr_num_pkg::COL_BIT_LEN-1:0]  col_sum [sqr_num_pkg::GRID_SIZE];
   sqr_num_pkg::word_t                   reduced [sqr_num_pkg::GRID_SIZE];

   always_ff @(posedge clk) begin
      if (load_operand) begin
         in_reg <= sq_in;
      end
   end

   always_comb begin
      for (int k = 0; k < sqr_num_pkg::NUM_ELEMENTS; k++) begin
         opnd[k] = use_input ? in_reg[k] : sq_out[k];   // Loopback after first pass
      end
   end

   // Each product splits at bit 16 into its own column and the next one
   always_comb begin : col_sums
      logic [2*sqr_num_pkg::BIT_LEN:0] prod;
      for (int k = 0; k < sqr_num_pkg::GRID_SIZE; k++) begin
         col_sum[k] = '0;
      end
      for (int i = 0; i < sqr_num_pkg::NUM_ELEMENTS; i++) begin
         for (int j = i; j < sqr_num_pkg::NUM_ELEMENTS; j++) begin
            prod = opnd[i] * opnd[j];
            if (i != j) begin
               prod = prod << 1;   // Off-diagonal terms appear twice
            end
            col_sum[i+j]   = col_sum[i+j] + prod[sqr_num_pkg::WORD_LEN-1:0];
            col_sum[i+j+1] = col_sum[i+j+1] + (prod >> sqr_num_pkg::WORD_LEN);
         end
      end
   end

   always_comb begin
      reduced[0] = sqr_num_pkg::word_t'(col_sum[0][sqr_num_pkg::WORD_LEN-1:0]);
      for (int k = 1; k < sqr_num_pkg::GRID_SIZE - 1; k++) begin
         reduced[k] = sqr_num_pkg::word_t'(col_sum[k][sqr_num_pkg::WORD_LEN-1:0])
                    + sqr_num_pkg::word_t'(col_sum[k-1] >> sqr_num_pkg::WORD_LEN);
      end
      // Top column keeps 17 bits, enough for operands below 2^96
      reduced[sqr_num_pkg::GRID_SIZE-1] = sqr_num_pkg::word_t'(
         col_sum[sqr_num_pkg::GRID_SIZE-1]
         + (col_sum[sqr_num_pkg::GRID_SIZE-2] >> sqr_num_pkg::WORD_LEN));
   end

   always_ff @(posedge clk) begin
      grid_words <= reduced;
   end

   for (genvar g = 0; g < sqr_num_pkg::GRID_SIZE; g++) begin : g_chk
      a_grid_known: assert property (@(posedge clk)
         use_input |=> !$isunknown(grid_words[g]));
   end

endmodule

`default_nettype wire

// File: verilog/reduction_rom.sv
// Reduction tables for the upper product columns
// One table per column 4 to 11, each row the column weight times the address mod p
// Low byte or high nine bits as address, registered read

`timescale 1ns/1ns
`default_nettype none

module reduction_rom (
   input  logic                    clk,
   input  logic                    shift_high,
   input  sqr_num_pkg::word_t      upper_words [sqr_num_pkg::GRID_SIZE-sqr_num_pkg::NONRED_ELEMENTS],
   output sqr_num_pkg::lut_entry_t lut_data    [sqr_num_pkg::GRID_SIZE-sqr_num_pkg::NONRED_ELEMENTS]
);

   for (genvar t = 0; t < sqr_num_pkg::GRID_SIZE - sqr_num_pkg::NONRED_ELEMENTS; t++) begin : g_table
      sqr_num_pkg::lut_entry_t mem [sqr_num_pkg::LUT_ENTRIES];
      sqr_num_pkg::lut_addr_t  addr;

      // Column index t+4 sets the weight 2^(16*(t+4))
      initial begin
         for (int a = 0; a < sqr_num_pkg::LUT_ENTRIES; a++) begin
            mem[a] = sqr_num_pkg::reduce_entry(t + sqr_num_pkg::NONRED_ELEMENTS,
                                               sqr_num_pkg::lut_addr_t'(a));
         end
      end

      always_comb begin
         if (shift_high) begin
            addr = upper_words[t][sqr_num_pkg::BIT_LEN-1:sqr_num_pkg::LOOK_UP_WIDTH];
         end else begin
            addr = {1'b0, upper_words[t][sqr_num_pkg::LOOK_UP_WIDTH-1:0]};   // Low byte
         end
      end

      always_ff @(posedge clk) begin
         lut_data[t] <= mem[addr];
      end
   end

endmodule

`default_nettype wire

// File: verilog/reduction_accumulator.sv
// Accumulator of the modular squarer
// Holds the low-byte lookup, sums lower grid columns with both lookups,
// partial carry reduction and the sq_out register

`timescale 1ns/1ns
`default_nettype none

module reduction_accumulator (
   input  logic                    clk,
   input  logic                    hold_low,
   input  logic                    write_result,
   input  sqr_num_pkg::word_t      lower_words [sqr_num_pkg::NONRED_ELEMENTS],
   input  sqr_num_pkg::lut_entry_t lut_data    [sqr_num_pkg::GRID_SIZE-sqr_num_pkg::NONRED_ELEMENTS],
   output sqr_num_pkg::word_t      sq_out      [sqr_num_pkg::NUM_ELEMENTS]
);

   sqr_num_pkg::lut_entry_t low_rows [sqr_num_pkg::GRID_SIZE-sqr_num_pkg::NONRED_ELEMENTS];
   sqr_num_pkg::acc_t       acc      [sqr_num_pkg::NONRED_ELEMENTS+1];
   sqr_num_pkg::word_t      reduced  [sqr_num_pkg::NUM_ELEMENTS];

   always_ff @(posedge clk) begin
      if (hold_low) begin
         low_rows <= lut_data;   // Low-byte rows, read one cycle earlier
      end
   end

   always_comb begin : col_acc
      logic [sqr_num_pkg::NONRED_ELEMENTS*sqr_num_pkg::WORD_LEN+sqr_num_pkg::LOOK_UP_WIDTH-1:0]
         shifted;
      for (int k = 0; k < sqr_num_pkg::NONRED_ELEMENTS; k++) begin
         acc[k] = sqr_num_pkg::acc_t'(lower_words[k]);
      end
      acc[sqr_num_pkg::NONRED_ELEMENTS] = '0;   // Collects only the table spill
      for (int r = 0; r < sqr_num_pkg::GRID_SIZE - sqr_num_pkg::NONRED_ELEMENTS; r++) begin
         // High nine bits carry a weight of 2^8
         shifted = {lut_data[r], {sqr_num_pkg::LOOK_UP_WIDTH{1'b0}}};
         for (int k = 0; k < sqr_num_pkg::NONRED_ELEMENTS; k++) begin
            acc[k] = acc[k]
                   + low_rows[r][k*sqr_num_pkg::WORD_LEN +: sqr_num_pkg::WORD_LEN]
                   + shifted[k*sqr_num_pkg::WORD_LEN +: sqr_num_pkg::WORD_LEN];
         end
         acc[sqr_num_pkg::NONRED_ELEMENTS] = acc[sqr_num_pkg::NONRED_ELEMENTS]
            + shifted[sqr_num_pkg::NONRED_ELEMENTS*sqr_num_pkg::WORD_LEN +:
                      sqr_num_pkg::LOOK_UP_WIDTH];   // Spill above bit 63
      end
   end

   always_comb begin
      reduced[0] = sqr_num_pkg::word_t'(acc[0][sqr_num_pkg::WORD_LEN-1:0]);
      for (int k = 1; k < sqr_num_pkg::NUM_ELEMENTS - 1; k++) begin
         reduced[k] = sqr_num_pkg::word_t'(acc[k][sqr_num_pkg::WORD_LEN-1:0])
                    + sqr_num_pkg::word_t'(acc[k-1] >> sqr_num_pkg::WORD_LEN);
      end
      // Top word is just the carry out of word 4
      reduced[sqr_num_pkg::NUM_ELEMENTS-1] = sqr_num_pkg::word_t'(
         acc[sqr_num_pkg::NUM_ELEMENTS-2] >> sqr_num_pkg::WORD_LEN);
   end

   always_ff @(posedge clk) begin
      if (write_result) begin
         sq_out <= reduced;
      end
   end

   for (genvar g = 0; g < sqr_num_pkg::NUM_ELEMENTS; g++) begin : g_chk
      a_out_stable: assert property (@(posedge clk)
         !$stable(sq_out[g]) |-> $past(write_result));
   end

endmodule

`default_nettype wire

// File: verilog/modular_square_top.sv
// Top level of the iterated modular squarer
// Sequencer, squaring grid, reduction tables and accumulator

`timescale 1ns/1ns
`default_nettype none

module modular_square_top (
   input  logic               clk,
   input  logic               reset,
   input  logic               start,
   input  sqr_num_pkg::word_t sq_in  [sqr_num_pkg::NUM_ELEMENTS],
   output sqr_num_pkg::word_t sq_out [sqr_num_pkg::NUM_ELEMENTS],
   output logic               valid
);

   logic                    load_operand;
   logic                    use_input;
   logic                    shift_high;
   logic                    hold_low;
   logic                    write_result;
   sqr_num_pkg::word_t      grid_words [sqr_num_pkg::GRID_SIZE];
   sqr_num_pkg::lut_entry_t lut_data   [sqr_num_pkg::GRID_SIZE-sqr_num_pkg::NONRED_ELEMENTS];

   square_sequencer u_sequencer (
      .clk          (clk),
      .reset        (reset),
      .start        (start),
      .load_operand (load_operand),
      .use_input    (use_input),
      .shift_high   (shift_high),
      .hold_low     (hold_low),
      .write_result (write_result),
      .valid        (valid)
   );

   square_grid u_grid (
      .clk          (clk),
      .load_operand (load_operand),
      .use_input    (use_input),
      .sq_in        (sq_in),
      .sq_out       (sq_out),
      .grid_words   (grid_words)
   );

   // Columns 4 to 11 are folded back through the tables
   reduction_rom u_rom (
      .clk          (clk),
      .shift_high   (shift_high),
      .upper_words  (grid_words[4:11]),
      .lut_data     (lut_data)
   );

   reduction_accumulator u_acc (
      .clk          (clk),
      .hold_low     (hold_low),
      .write_result (write_result),
      .lower_words  (grid_words[0:3]),
      .lut_data     (lut_data),
      .sq_out       (sq_out)
   );

endmodule

`default_nettype wire

// File: bench/tb_modular_square.sv
// Testbench for the iterated modular squarer
// Stimulus table with expected residues, reference model, pulse timing checks
// Mid-run reset between rows, start pokes during a run and a watchdog

`timescale 1ns/1ns
`default_nettype none

module tb_modular_square;

   localparam int CLK_PERIOD   = 10;
   localparam int RESET_CYCLES = 5;
   localparam int NUM_ROWS     = 8;
   localparam int MAX_ITERS    = 6;
   localparam int SLACK_CYCLES = 10;
   localparam int ITER         = sqr_ctrl_pkg::ITER_CYCLES;
   localparam int WATCHDOG_CYCLES =
      NUM_ROWS * (MAX_ITERS + RESET_CYCLES + SLACK_CYCLES) * ITER;

   logic               clk = 1'b0;
   logic               reset;
   logic               start;
   sqr_num_pkg::word_t sq_in  [sqr_num_pkg::NUM_ELEMENTS];
   sqr_num_pkg::word_t sq_out [sqr_num_pkg::NUM_ELEMENTS];
   logic               valid;

   sqr_num_pkg::word_t stim_words [NUM_ROWS][sqr_num_pkg::NUM_ELEMENTS];
   int                 stim_iters [NUM_ROWS];
   bit                 stim_poke  [NUM_ROWS];   // Pulse start again after the first valid
   logic [63:0]        expect_tab [NUM_ROWS][MAX_ITERS];

   int          cycle_cnt = 0;
   int          errors = 0;
   int          checks = 0;

   modular_square_top dut0 (
      .clk    (clk),
      .reset  (reset),
      .start  (start),
      .sq_in  (sq_in),
      .sq_out (sq_out),
      .valid  (valid)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

   // Value of a redundant operand, word k weighs 2^(16k)
   function automatic logic [127:0] weighted_value(
         input sqr_num_pkg::word_t w [sqr_num_pkg::NUM_ELEMENTS]);
      logic [127:0] v;
      v = '0;
      for (int k = 0; k < sqr_num_pkg::NUM_ELEMENTS; k++) begin
         v = v + (128'(w[k]) << (sqr_num_pkg::WORD_LEN * k));
      end
      return v;
   endfunction

   function automatic logic [127:0] square_mod(input logic [127:0] x);
      return (x * x) % 128'(sqr_num_pkg::MODULUS);   // x below 2^64, product fits
   endfunction

   task automatic set_row(input int r, input logic [16:0] w0, w1, w2, w3, w4, w5,
                          input int n, input bit poke);
      logic [127:0] x;
      stim_words[r] = '{w0, w1, w2, w3, w4, w5};
      stim_iters[r] = n;
      stim_poke[r]  = poke;
      x = weighted_value(stim_words[r]) % 128'(sqr_num_pkg::MODULUS);
      for (int k = 0; k < MAX_ITERS; k++) begin
         x = square_mod(x);
         expect_tab[r][k] = x[63:0];
      end
   endtask

   task automatic apply_reset();
      @(posedge clk);
      #1 reset = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      #1 reset = 1'b0;
   endtask

   task automatic check_quiet(input int n);
      repeat (n) begin
         @(negedge clk);
         checks++;
         if (valid) begin
            $display("CHECK FAILED at %0t: valid high while no run is active", $time);
            errors++;
         end
      end
   endtask

   task automatic run_row(input int r);
      int           pulses;
      int           waited;
      int           last_cycle;
      logic [127:0] got;
      @(posedge clk);
      #1 start = 1'b1;
      for (int k = 0; k < sqr_num_pkg::NUM_ELEMENTS; k++) begin
         sq_in[k] = stim_words[r][k];
      end
      @(posedge clk);   // Start edge
      #1 start = 1'b0;
      @(negedge clk);
      last_cycle = cycle_cnt;
      pulses = 0;
      while (pulses < stim_iters[r]) begin
         waited = 0;
         do begin
            @(negedge clk);
            waited++;
         end while (!valid && waited < 3 * ITER);
         if (!valid) begin
            $display("Error at %0t: row %0d gave no valid pulse after %0d pulses",
                     $time, r, pulses);
            errors++;
            return;
         end
         checks += 2;
         if (cycle_cnt - last_cycle != ITER) begin
            $display("CHECK FAILED at %0t: row %0d pulse %0d came %0d cycles late",
                     $time, r, pulses + 1, cycle_cnt - last_cycle);
            errors++;
         end
         last_cycle = cycle_cnt;
         got = weighted_value(sq_out) % 128'(sqr_num_pkg::MODULUS);
         if (got[63:0] != expect_tab[r][pulses]) begin
            $display("CHECK FAILED at %0t: row %0d pulse %0d residue %h expected %h",
                     $time, r, pulses + 1, got[63:0], expect_tab[r][pulses]);
            errors++;
         end
         pulses++;
         if (pulses == 1 && stim_poke[r]) begin
            @(posedge clk);
            #1 start = 1'b1;   // Must be ignored outside IDLE
            @(posedge clk);
            #1 start = 1'b0;
         end
      end
   endtask

   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
      $display("Regression failed");
      $finish;
   end

   initial begin
      void'($urandom(21));
      reset = 1'b1;
      start = 1'b0;
      for (int k = 0; k < sqr_num_pkg::NUM_ELEMENTS; k++) begin
         sq_in[k] = '0;
      end
      set_row(0, 17'h3, 17'h0, 17'h0, 17'h0, 17'h0, 17'h0, 6, 1'b0);
      set_row(1, 17'h1234, 17'h5678, 17'h9ABC, 17'hDEF0, 17'h0, 17'h0, 4, 1'b0);
      // Above the modulus, then the modulus itself
      set_row(2, 17'hFFFF, 17'hFFFF, 17'hFFFF, 17'hFFFF, 17'h0, 17'h0, 3, 1'b0);
      set_row(3, 17'h1FFFF, 17'h1FFFF, 17'h1FFFF, 17'h1FFFF, 17'h1FFFF, 17'h000FF, 5, 1'b0);
      set_row(4, 17'hAAAA, 17'h5555, 17'h1AAAA, 17'h15555, 17'h0003, 17'h0, 4, 1'b1);
      set_row(5, 17'hFFC5, 17'hFFFF, 17'hFFFF, 17'hFFFF, 17'h0, 17'h0, 2, 1'b0);
      for (int r = 6; r < NUM_ROWS; r++) begin
         set_row(r, 17'($urandom), 17'($urandom), 17'($urandom), 17'($urandom),
                 17'($urandom), 17'($urandom & 32'hFF), 1 + int'($urandom % 6), r[0]);
      end
      repeat (RESET_CYCLES) @(posedge clk);
      #1 reset = 1'b0;
      check_quiet(20);
      for (int r = 0; r < NUM_ROWS; r++) begin
         run_row(r);
         apply_reset();   // Cuts the run short
         check_quiet(2 * ITER);
      end
      $display("Checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: tb.f
verilog/sqr_num_pkg.sv
verilog/sqr_ctrl_pkg.sv
verilog/square_sequencer.sv
verilog/square_grid.sv
verilog/reduction_rom.sv
verilog/reduction_accumulator.sv
verilog/modular_square_top.sv
bench/tb_modular_square.sv

// File: Bender.yml
package:
  name: modular_square

sources:
  - verilog/sqr_num_pkg.sv
  - verilog/sqr_ctrl_pkg.sv
  - verilog/square_sequencer.sv
  - verilog/square_grid.sv
  - verilog/reduction_rom.sv
  - verilog/reduction_accumulator.sv
  - verilog/modular_square_top.sv
  - target: test
    files:
      - bench/tb_modular_square.sv
